// File: dataCache.f
dataCachePkg.sv
cacheAddrDecode.sv
cacheStorage.sv
cacheController.sv
cacheResponse.sv
dataCache.sv
dataCacheChecker.sv
dataCacheAssertions.sv
dataCacheTb.sv

// File: Makefile
VERILATOR ?= verilator
VFLAGS    ?= --timing --assert
TOP       ?= dataCacheTb
FILELIST  ?= dataCache.f
LOG       ?= sim.log

.PHONY: lint sim clean

lint:
	$(VERILATOR) --lint-only $(VFLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) --binary $(VFLAGS) --top-module $(TOP) -f $(FILELIST)
	-./obj_dir/V$(TOP) > $(LOG) 2>&1
	cat $(LOG)
	@if grep -q "TEST RESULT: FAIL" $(LOG); then exit 1; fi
	@grep -q "TEST RESULT: PASS" $(LOG)

clean:
	rm -rf obj_dir $(LOG)

// File: dataCacheTb.sv
`timescale 1ns/10ps
`default_nettype none

module dataCacheTb
    import dataCachePkg::*;
;

    localparam int NUM_TESTS = 15;
    localparam int CYCLE_LIMIT = NUM_TESTS * 40;

    typedef struct {
        logic   write;
        wordT   addr;
        wordT   wdata;
        byteEnT byteEn;
        wordT   expWord;
        int     expReads;
        int     expWrites;
    } stimT;

    logic   CLK = 1'b0;
    logic   rst;
    logic   reqValid, reqWrite, reqReady;
    wordT   reqAddr, reqWdata;
    byteEnT reqByteEn;
    logic   rspValid, rspReady;
    wordT   rspData;
    logic   memReqValid, memReqWrite, memReqReady, memRspValid;
    wordT   memAddr, memWdata, memRdata;
    logic   expPush;
    wordT   expWord;
    int     expReads, expWrites;
    int     doneCount, errorCount;
    int     cycles;
    stimT   stimTable [NUM_TESTS];
    wordT   memory [wordT];
    logic [31:0] memRng, rspRng;
    int     memWait, rspWait, retCount;
    wordT   retData;

    always #5 CLK = ~CLK;

    dataCache #(.SET_BITS(2)) i_dataCache (
        .CLK(CLK), .rst(rst), .reqValid(reqValid), .reqWrite(reqWrite), .reqAddr(reqAddr),
        .reqWdata(reqWdata), .reqByteEn(reqByteEn), .reqReady(reqReady),
        .rspValid(rspValid), .rspData(rspData), .rspReady(rspReady),
        .memReqValid(memReqValid), .memReqWrite(memReqWrite), .memAddr(memAddr),
        .memWdata(memWdata), .memReqReady(memReqReady), .memRspValid(memRspValid),
        .memRdata(memRdata)
    );

    dataCacheChecker i_checker (
        .CLK(CLK), .rst(rst), .expPush(expPush), .expWord(expWord), .expReads(expReads),
        .expWrites(expWrites), .rspValid(rspValid), .rspReady(rspReady), .rspData(rspData),
        .memReqValid(memReqValid), .memReqReady(memReqReady), .memReqWrite(memReqWrite),
        .doneCount(doneCount), .errorCount(errorCount)
    );

    bind dataCache dataCacheAssertions i_assertions (
        .CLK(CLK), .rst(rst), .reqValid(reqValid), .reqReady(reqReady),
        .reqWrite(reqWrite), .reqAddr(reqAddr), .reqWdata(reqWdata), .reqByteEn(reqByteEn),
        .rspValid(rspValid), .rspReady(rspReady), .rspData(rspData),
        .memReqValid(memReqValid)
    );

    function automatic logic [31:0] lcgNext(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    // Untouched memory words follow a pattern of the full address
    function automatic wordT memRead(input wordT addr);
        if (memory.exists(addr)) begin
            return memory[addr];
        end
        return addr ^ 32'hA5A5_0000;
    endfunction

    task automatic setEntry(input int idx, input logic write, input wordT addr,
                            input wordT wdata, input byteEnT byteEn, input wordT expWord,
                            input int reads, input int writes);
        stimTable[idx] = '{write, addr, wdata, byteEn, expWord, reads, writes};
    endtask

    task automatic fillTable();
        // Cold miss, hit, partial write and read back in set 0
        setEntry(0, 1'b0, 32'h0000_0100, 32'h0, 4'h0, 32'hA5A5_0100, 1, 0);
        setEntry(1, 1'b0, 32'h0000_0100, 32'h0, 4'h0, 32'hA5A5_0100, 0, 0);
        setEntry(2, 1'b1, 32'h0000_0100, 32'h1122_3344, 4'b0101, 32'hA522_0144, 0, 0);
        setEntry(3, 1'b0, 32'h0000_0100, 32'h0, 4'h0, 32'hA522_0144, 0, 0);
        // Two dirty lines in set 1 and then evictions with writeback
        setEntry(4, 1'b1, 32'h0000_1004, 32'hDEAD_BEEF, 4'b1111, 32'hDEAD_BEEF, 1, 0);
        setEntry(5, 1'b1, 32'h0000_2004, 32'hCAFE_0000, 4'b1100, 32'hCAFE_2004, 1, 0);
        setEntry(6, 1'b0, 32'h0000_3004, 32'h0, 4'h0, 32'hA5A5_3004, 1, 1);
        setEntry(7, 1'b0, 32'h0000_1004, 32'h0, 4'h0, 32'hDEAD_BEEF, 1, 1);
        // In set 2 the order A, B, A, C leaves A resident and evicts B
        setEntry(8, 1'b0, 32'h0000_1008, 32'h0, 4'h0, 32'hA5A5_1008, 1, 0);
        setEntry(9, 1'b0, 32'h0000_2008, 32'h0, 4'h0, 32'hA5A5_2008, 1, 0);
        setEntry(10, 1'b0, 32'h0000_1008, 32'h0, 4'h0, 32'hA5A5_1008, 0, 0);
        setEntry(11, 1'b0, 32'h0000_3008, 32'h0, 4'h0, 32'hA5A5_3008, 1, 0);
        setEntry(12, 1'b0, 32'h0000_1008, 32'h0, 4'h0, 32'hA5A5_1008, 0, 0);
        setEntry(13, 1'b0, 32'h0000_2008, 32'h0, 4'h0, 32'hA5A5_2008, 1, 0);
        setEntry(14, 1'b0, 32'h0000_2004, 32'h0, 4'h0, 32'hCAFE_2004, 1, 0);
    endtask

    // Memory request port with random stalls of 0 to 3 cycles
    always @(posedge CLK) begin
        memRspValid <= 1'b0;
        if (rst) begin
            memReqReady <= 1'b0;
            memWait     = 0;
            retCount    = 0;
        end else begin
            if (retCount != 0) begin
                if (retCount == 1) begin
                    memRspValid <= 1'b1;
                    memRdata    <= retData;
                end
                retCount = retCount - 1;
            end
            if (memReqValid && memReqReady) begin
                if (memReqWrite) begin
                    memory[memAddr] = memWdata;
                end else begin
                    retData  = memRead(memAddr);
                    memRng   = lcgNext(memRng);
                    retCount = 1 + int'(memRng[17:16] % 3);
                end
                memReqReady <= 1'b0;
                memRng = lcgNext(memRng);
                memWait = int'(memRng[17:16]);
            end else if (memReqValid && !memReqReady) begin
                if (memWait == 0) begin
                    memReqReady <= 1'b1;
                end else begin
                    memWait = memWait - 1;
                end
            end
        end
    end

    // Response back-pressure
    always @(posedge CLK) begin
        if (rst) begin
            rspReady <= 1'b0;
            rspWait  = 0;
        end else if (rspValid && rspReady) begin
            rspReady <= 1'b0;
            rspRng = lcgNext(rspRng);
            rspWait = int'(rspRng[17:16]);
        end else if (rspValid && !rspReady) begin
            if (rspWait == 0) begin
                rspReady <= 1'b1;
            end else begin
                rspWait = rspWait - 1;
            end
        end
    end

    always @(posedge CLK) begin
        cycles <= cycles + 1;
        if (cycles >= CYCLE_LIMIT) begin
            $display("run stopped after %0d cycles with %0d of %0d responses", cycles,
                     doneCount, NUM_TESTS);
            $display("TEST RESULT: FAIL");
            $finish;
        end
    end

    initial begin
        rst         = 1'b1;
        reqValid    = 1'b0;
        reqWrite    = 1'b0;
        reqAddr     = '0;
        reqWdata    = '0;
        reqByteEn   = '0;
        rspReady    = 1'b0;
        memReqReady = 1'b0;
        memRspValid = 1'b0;
        memRdata    = '0;
        expPush     = 1'b0;
        expWord     = '0;
        expReads    = 0;
        expWrites   = 0;
        cycles      = 0;
        memRng      = 32'he986_1fff;
        rspRng      = lcgNext(32'he986_1fff);
        fillTable();
        repeat (5) @(posedge CLK);
        rst <= 1'b0;
        for (int i = 0; i < NUM_TESTS; i++) begin
            @(posedge CLK);
            expPush   <= 1'b0;
            reqValid  <= 1'b1;
            reqWrite  <= stimTable[i].write;
            reqAddr   <= stimTable[i].addr;
            reqWdata  <= stimTable[i].wdata;
            reqByteEn <= stimTable[i].byteEn;
            @(posedge CLK);
            while (!reqReady) begin
                @(posedge CLK);
            end
            // The request transferred on this edge
            reqValid  <= 1'b0;
            expPush   <= 1'b1;
            expWord   <= stimTable[i].expWord;
            expReads  <= stimTable[i].expReads;
            expWrites <= stimTable[i].expWrites;
        end
        @(posedge CLK);
        expPush <= 1'b0;
        while (doneCount < NUM_TESTS) begin
            @(posedge CLK);
        end
        @(posedge CLK);
        $display("tests %0d, errors %0d, assertion failures %0d", doneCount, errorCount,
                 i_dataCache.i_assertions.failCount);
        if (errorCount == 0 && i_dataCache.i_assertions.failCount == 0) begin
            $display("TEST RESULT: PASS");
        end else begin
            $display("TEST RESULT: FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: dataCacheAssertions.sv
`timescale 1ns/10ps
`default_nettype none

module dataCacheAssertions
    import dataCachePkg::*;
(
    input logic   CLK,
    input logic   rst,
    input logic   reqValid,
    input logic   reqReady,
    input logic   reqWrite,
    input wordT   reqAddr,
    input wordT   reqWdata,
    input byteEnT reqByteEn,
    input logic   rspValid,
    input logic   rspReady,
    input wordT   rspData,
    input logic   memReqValid
);

    // Number of failed assertions so far
    int failCount = 0;

    reqStable: assert property (@(posedge CLK) disable iff (rst)
        reqValid && !reqReady |=> reqValid && $stable(reqWrite) && $stable(reqAddr)
            && $stable(reqWdata) && $stable(reqByteEn))
        else begin
            failCount++;
            $error("request fields changed while the request was stalled");
        end

    rspHold: assert property (@(posedge CLK) disable iff (rst)
        rspValid && !rspReady |=> rspValid && $stable(rspData))
        else begin
            failCount++;
            $error("response dropped or changed before it was accepted");
        end

    memIdleAfterReset: assert property (@(posedge CLK) rst |=> !memReqValid)
        else begin
            failCount++;
            $error("memory request raised right after reset");
        end

endmodule

`default_nettype wire

// File: dataCacheChecker.sv
`timescale 1ns/10ps
`default_nettype none

module dataCacheChecker
    import dataCachePkg::*;
(
    input  logic   CLK,
    input  logic   rst,
    input  logic   expPush,
    input  wordT   expWord,
    input  int     expReads,
    input  int     expWrites,
    input  logic   rspValid,
    input  logic   rspReady,
    input  wordT   rspData,
    input  logic   memReqValid,
    input  logic   memReqReady,
    input  logic   memReqWrite,
    output int     doneCount,
    output int     errorCount
);

    wordT wordQueue [$];
    int   readsQueue [$];
    int   writesQueue [$];
    int   readsSeen;
    int   writesSeen;

    always @(posedge CLK) begin
        int   testErrors;
        wordT wantWord;
        int   wantReads;
        int   wantWrites;
        if (rst) begin
            doneCount  <= 0;
            errorCount <= 0;
            readsSeen  = 0;
            writesSeen = 0;
        end else begin
            if (expPush) begin
                wordQueue.push_back(expWord);
                readsQueue.push_back(expReads);
                writesQueue.push_back(expWrites);
            end
            if (memReqValid && memReqReady) begin
                if (memReqWrite) begin
                    writesSeen = writesSeen + 1;
                end else begin
                    readsSeen = readsSeen + 1;
                end
            end
            if (rspValid && rspReady) begin
                testErrors = 0;
                if (wordQueue.size() == 0) begin
                    $display("response %0d arrived with no request outstanding", doneCount);
                    testErrors = 1;
                end else begin
                    wantWord   = wordQueue.pop_front();
                    wantReads  = readsQueue.pop_front();
                    wantWrites = writesQueue.pop_front();
                    if (rspData !== wantWord) begin
                        $display("MISMATCH test %0d rspData got %h expected %h",
                                 doneCount, rspData, wantWord);
                        testErrors++;
                    end
                    if (readsSeen != wantReads) begin
                        $display("MISMATCH test %0d memory reads got %h expected %h",
                                 doneCount, readsSeen, wantReads);
                        testErrors++;
                    end
                    if (writesSeen != wantWrites) begin
                        $display("MISMATCH test %0d memory writes got %h expected %h",
                                 doneCount, writesSeen, wantWrites);
                        testErrors++;
                    end
                end
                if (testErrors == 0) begin
                    $display("test %0d done: ok", doneCount);
                end else begin
                    $display("test %0d done: %0d errors", doneCount, testErrors);
                end
                // Memory traffic is counted per request between two responses
                readsSeen  = 0;
                writesSeen = 0;
                doneCount  <= doneCount + 1;
                errorCount <= errorCount + testErrors;
            end
        end
    end

endmodule

`default_nettype wire

// File: dataCache.sv
`timescale 1ns/10ps
`default_nettype none

module dataCache
    import dataCachePkg::*;
#(
    parameter int SET_BITS = 2
) (
    input  logic   CLK,
    input  logic   rst,
    input  logic   reqValid,
    input  logic   reqWrite,
    input  wordT   reqAddr,
    input  wordT   reqWdata,
    input  byteEnT reqByteEn,
    output logic   reqReady,
    output logic   rspValid,
    output wordT   rspData,
    input  logic   rspReady,
    output logic   memReqValid,
    output logic   memReqWrite,
    output wordT   memAddr,
    output wordT   memWdata,
    input  logic   memReqReady,
    input  logic   memRspValid,
    input  wordT   memRdata
);

    localparam int TAG_BITS = WORD_BITS - SET_BITS - WORD_OFFSET_BITS;

    wordT                curAddr;
    logic [TAG_BITS-1:0] reqTag;
    logic [SET_BITS-1:0] reqSet;
    logic                hit;
    logic                hitWay;
    logic [TAG_BITS-1:0] tag0;
    logic [TAG_BITS-1:0] tag1;
    logic                valid0;
    logic                valid1;
    logic                dirty0;
    logic                dirty1;
    wordT                data0;
    wordT                data1;
    logic                lruWay0;
    logic                wrEn;
    logic                wrWay;
    logic [TAG_BITS-1:0] wrTag;
    wordT                wrData;
    logic                wrDirty;
    logic                lruWrEn;
    logic                lruWay;
    logic                rspLoad;
    wordT                rspWord;
    logic                rspBusy;

    cacheAddrDecode #(.SET_BITS(SET_BITS)) i_decode (
        .reqAddr(curAddr), .tag0(tag0), .tag1(tag1), .valid0(valid0), .valid1(valid1),
        .reqTag(reqTag), .reqSet(reqSet), .hit(hit), .hitWay(hitWay)
    );

    cacheStorage #(.SET_BITS(SET_BITS)) i_storage (
        .CLK(CLK), .rst(rst), .rdSet(reqSet),
        .wrEn(wrEn), .wrWay(wrWay), .wrDirty(wrDirty), .wrTag(wrTag), .wrData(wrData),
        .lruWrEn(lruWrEn), .lruWay(lruWay),
        .tag0(tag0), .tag1(tag1), .valid0(valid0), .valid1(valid1),
        .dirty0(dirty0), .dirty1(dirty1), .data0(data0), .data1(data1), .lruWay0(lruWay0)
    );

    cacheController #(.SET_BITS(SET_BITS)) i_controller (
        .CLK(CLK), .rst(rst),
        .reqValid(reqValid), .reqWrite(reqWrite), .reqAddr(reqAddr), .reqWdata(reqWdata),
        .reqByteEn(reqByteEn), .reqReady(reqReady), .curAddr(curAddr),
        .hit(hit), .hitWay(hitWay), .reqTag(reqTag), .reqSet(reqSet),
        .tag0(tag0), .tag1(tag1), .dirty0(dirty0), .dirty1(dirty1),
        .data0(data0), .data1(data1), .lruWay0(lruWay0),
        .wrEn(wrEn), .wrWay(wrWay), .wrTag(wrTag), .wrData(wrData), .wrDirty(wrDirty),
        .lruWrEn(lruWrEn), .lruWay(lruWay),
        .memReqValid(memReqValid), .memReqWrite(memReqWrite), .memAddr(memAddr),
        .memWdata(memWdata), .memReqReady(memReqReady), .memRspValid(memRspValid),
        .memRdata(memRdata), .rspLoad(rspLoad), .rspWord(rspWord), .rspBusy(rspBusy)
    );

    cacheResponse i_response (
        .CLK(CLK), .rst(rst), .rspLoad(rspLoad), .rspWord(rspWord), .rspReady(rspReady),
        .rspValid(rspValid), .rspData(rspData), .rspBusy(rspBusy)
    );

endmodule

`default_nettype wire

// File: cacheResponse.sv
`timescale 1ns/10ps
`default_nettype none

module cacheResponse
    import dataCachePkg::*;
(
    input  logic CLK,
    input  logic rst,
    input  logic rspLoad,
    input  wordT rspWord,
    input  logic rspReady,
    output logic rspValid,
    output wordT rspData,
    output logic rspBusy
);

    always_ff @(posedge CLK) begin
        if (rst) begin
            rspValid <= 1'b0;
        end else if (rspLoad) begin
            rspValid <= 1'b1;
        end else if (rspValid && rspReady) begin
            rspValid <= 1'b0;
        end
    end

    // The word is only replaced by a new load, never while it is still held
    always_ff @(posedge CLK) begin
        if (rspLoad) begin
            rspData <= rspWord;
        end
    end

    // A word being loaded this cycle counts as held
    assign rspBusy = rspValid || rspLoad;

endmodule

`default_nettype wire

// File: cacheController.sv
`timescale 1ns/10ps
`default_nettype none

module cacheController
    import dataCachePkg::*;
#(
    parameter int SET_BITS = 2
) (
    input  logic                                        CLK,
    input  logic                                        rst,
    input  logic                                        reqValid,
    input  logic                                        reqWrite,
    input  wordT                                        reqAddr,
    input  wordT                                        reqWdata,
    input  byteEnT                                      reqByteEn,
    output logic                                        reqReady,
    output wordT                                        curAddr,
    input  logic                                        hit,
    input  logic                                        hitWay,
    input  logic [WORD_BITS-SET_BITS-WORD_OFFSET_BITS-1:0] reqTag,
    input  logic [SET_BITS-1:0]                         reqSet,
    input  logic [WORD_BITS-SET_BITS-WORD_OFFSET_BITS-1:0] tag0,
    input  logic [WORD_BITS-SET_BITS-WORD_OFFSET_BITS-1:0] tag1,
    input  logic                                        dirty0,
    input  logic                                        dirty1,
    input  wordT                                        data0,
    input  wordT                                        data1,
    input  logic                                        lruWay0,
    output logic                                        wrEn,
    output logic                                        wrWay,
    output logic [WORD_BITS-SET_BITS-WORD_OFFSET_BITS-1:0] wrTag,
    output wordT                                        wrData,
    output logic                                        wrDirty,
    output logic                                        lruWrEn,
    output logic                                        lruWay,
    output logic                                        memReqValid,
    output logic                                        memReqWrite,
    output wordT                                        memAddr,
    output wordT                                        memWdata,
    input  logic                                        memReqReady,
    input  logic                                        memRspValid,
    input  wordT                                        memRdata,
    output logic                                        rspLoad,
    output wordT                                        rspWord,
    input  logic                                        rspBusy
);

    localparam int TAG_BITS = WORD_BITS - SET_BITS - WORD_OFFSET_BITS;

    ctrlStateT            state;
    ctrlStateT            nextState;
    logic                 writeQ;
    wordT                 wdataQ;
    byteEnT               byteEnQ;
    logic                 victimWay;
    logic [TAG_BITS-1:0]  victimTag;
    logic                 victimDirty;
    wordT                 hitWord;
    wordT                 hitMerged;
    wordT                 refillMerged;

    function automatic wordT mergeBytes(input wordT oldWord, input wordT newWord,
                                        input byteEnT byteEn);
        wordT result;
        result = oldWord;
        for (int i = 0; i < BYTE_LANES; i++) begin
            if (byteEn[i]) begin
                result[i*BYTE_BITS +: BYTE_BITS] = newWord[i*BYTE_BITS +: BYTE_BITS];
            end
        end
        return result;
    endfunction

    assign reqReady = (state == IDLE) && !rspBusy;

    // Victim choice is taken from the LRU bit during LOOKUP and held for the miss
    assign victimTag   = victimWay ? tag1 : tag0;
    assign victimDirty = lruWay0 ? dirty1 : dirty0;

    assign hitWord      = hitWay ? data1 : data0;
    assign hitMerged    = writeQ ? mergeBytes(hitWord, wdataQ, byteEnQ) : hitWord;
    assign refillMerged = writeQ ? mergeBytes(memRdata, wdataQ, byteEnQ) : memRdata;

    assign memReqValid = (state == WRITEBACK) || (state == REFILL_REQ);
    assign memReqWrite = (state == WRITEBACK);
    assign memWdata    = victimWay ? data1 : data0;
    assign memAddr     = (state == WRITEBACK) ?
                         {victimTag, reqSet, {WORD_OFFSET_BITS{1'b0}}} :
                         {reqTag, reqSet, {WORD_OFFSET_BITS{1'b0}}};

    always_ff @(posedge CLK) begin
        if (rst) begin
            state <= IDLE;
        end else begin
            state <= nextState;
        end
    end

    // Request fields are captured at acceptance and drive the lookup until done
    always_ff @(posedge CLK) begin
        if (reqValid && reqReady) begin
            writeQ  <= reqWrite;
            curAddr <= reqAddr;
            wdataQ  <= reqWdata;
            byteEnQ <= reqByteEn;
        end
        if (state == LOOKUP) begin
            victimWay <= lruWay0;
        end
    end

    always_comb begin
        nextState = state;
        wrEn      = 1'b0;
        wrWay     = hitWay;
        wrTag     = reqTag;
        wrData    = hitMerged;
        wrDirty   = 1'b1;
        lruWrEn   = 1'b0;
        lruWay    = !hitWay;
        rspLoad   = 1'b0;
        rspWord   = hitMerged;
        case (state)
            IDLE: begin
                if (reqValid && reqReady) begin
                    nextState = LOOKUP;
                end
            end
            LOOKUP: begin
                if (hit) begin
                    wrEn      = writeQ;
                    lruWrEn   = 1'b1;
                    rspLoad   = 1'b1;
                    nextState = IDLE;
                end else if (victimDirty) begin
                    nextState = WRITEBACK;
                end else begin
                    nextState = REFILL_REQ;
                end
            end
            WRITEBACK: begin
                if (memReqReady) begin
                    nextState = REFILL_REQ;
                end
            end
            REFILL_REQ: begin
                if (memReqReady) begin
                    nextState = REFILL_WAIT;
                end
            end
            REFILL_WAIT: begin
                wrWay   = victimWay;
                wrData  = refillMerged;
                wrDirty = writeQ;
                lruWay  = !victimWay;
                rspWord = refillMerged;
                if (memRspValid) begin
                    wrEn      = 1'b1;
                    lruWrEn   = 1'b1;
                    rspLoad   = 1'b1;
                    nextState = RESPOND;
                end
            end
            RESPOND: begin
                // Miss responses drain before the controller goes idle again
                if (!rspBusy) begin
                    nextState = IDLE;
                end
            end
            default: nextState = IDLE;
        endcase
    end

endmodule

`default_nettype wire

// File: cacheStorage.sv
`timescale 1ns/10ps
`default_nettype none

module cacheStorage
    import dataCachePkg::*;
#(
    parameter int SET_BITS = 2
) (
    input  logic                                        CLK,
    input  logic                                        rst,
    input  logic [SET_BITS-1:0]                         rdSet,
    input  logic                                        wrEn,
    input  logic                                        wrWay,
    input  logic                                        wrDirty,
    input  logic [WORD_BITS-SET_BITS-WORD_OFFSET_BITS-1:0] wrTag,
    input  wordT                                        wrData,
    input  logic                                        lruWrEn,
    input  logic                                        lruWay,
    output logic [WORD_BITS-SET_BITS-WORD_OFFSET_BITS-1:0] tag0,
    output logic [WORD_BITS-SET_BITS-WORD_OFFSET_BITS-1:0] tag1,
    output logic                                        valid0,
    output logic                                        valid1,
    output logic                                        dirty0,
    output logic                                        dirty1,
    output wordT                                        data0,
    output wordT                                        data1,
    output logic                                        lruWay0
);

    localparam int TAG_BITS = WORD_BITS - SET_BITS - WORD_OFFSET_BITS;
    localparam int NUM_SETS = 2 ** SET_BITS;

    typedef logic [TAG_BITS-1:0] tagT;

    tagT                 tagArr0 [NUM_SETS];
    tagT                 tagArr1 [NUM_SETS];
    wordT                dataArr0 [NUM_SETS];
    wordT                dataArr1 [NUM_SETS];
    logic [NUM_SETS-1:0] validBits0;
    logic [NUM_SETS-1:0] validBits1;
    logic [NUM_SETS-1:0] dirtyBits0;
    logic [NUM_SETS-1:0] dirtyBits1;
    logic [NUM_SETS-1:0] lruBits;

    // Valid, dirty and LRU bits of every set
    always_ff @(posedge CLK) begin
        if (rst) begin
            validBits0 <= '0;
            validBits1 <= '0;
            dirtyBits0 <= '0;
            dirtyBits1 <= '0;
            lruBits    <= '0;
        end else begin
            if (wrEn && !wrWay) begin
                validBits0[rdSet] <= 1'b1;
                dirtyBits0[rdSet] <= wrDirty;
            end
            if (wrEn && wrWay) begin
                validBits1[rdSet] <= 1'b1;
                dirtyBits1[rdSet] <= wrDirty;
            end
            if (lruWrEn) begin
                lruBits[rdSet] <= lruWay;
            end
        end
    end

    always_ff @(posedge CLK) begin
        if (wrEn && !wrWay) begin
            tagArr0[rdSet]  <= wrTag;
            dataArr0[rdSet] <= wrData;
        end
        if (wrEn && wrWay) begin
            tagArr1[rdSet]  <= wrTag;
            dataArr1[rdSet] <= wrData;
        end
    end

    assign tag0    = tagArr0[rdSet];
    assign tag1    = tagArr1[rdSet];
    assign data0   = dataArr0[rdSet];
    assign data1   = dataArr1[rdSet];
    assign valid0  = validBits0[rdSet];
    assign valid1  = validBits1[rdSet];
    assign dirty0  = dirtyBits0[rdSet];
    assign dirty1  = dirtyBits1[rdSet];
    assign lruWay0 = lruBits[rdSet];

endmodule

`default_nettype wire

// File: cacheAddrDecode.sv
`timescale 1ns/10ps
`default_nettype none

module cacheAddrDecode
    import dataCachePkg::*;
#(
    parameter int SET_BITS = 2
) (
    input  wordT                                        reqAddr,
    input  logic [WORD_BITS-SET_BITS-WORD_OFFSET_BITS-1:0] tag0,
    input  logic [WORD_BITS-SET_BITS-WORD_OFFSET_BITS-1:0] tag1,
    input  logic                                        valid0,
    input  logic                                        valid1,
    output logic [WORD_BITS-SET_BITS-WORD_OFFSET_BITS-1:0] reqTag,
    output logic [SET_BITS-1:0]                         reqSet,
    output logic                                        hit,
    output logic                                        hitWay
);

    localparam int TAG_BITS = WORD_BITS - SET_BITS - WORD_OFFSET_BITS;

    logic match0;
    logic match1;

    // The low two address bits select a byte and play no part in the lookup
    assign reqTag = reqAddr[WORD_BITS-1 -: TAG_BITS];
    assign reqSet = reqAddr[WORD_OFFSET_BITS +: SET_BITS];

    assign match0 = valid0 && (tag0 == reqTag);
    assign match1 = valid1 && (tag1 == reqTag);

    assign hit = match0 || match1;

    // Both ways never hold the same tag, so way 1 only wins when it matches
    assign hitWay = match1;

endmodule

`default_nettype wire

// File: dataCachePkg.sv
`default_nettype none

package dataCachePkg;

    // Fixed field widths of the data path
    localparam int WORD_BITS = 32;
    localparam int BYTE_BITS = 8;
    localparam int BYTE_LANES = WORD_BITS / BYTE_BITS;

    // Byte offset inside a word, dropped from every cache index
    localparam int WORD_OFFSET_BITS = 2;

    // Data word and byte address share one width
    typedef logic [WORD_BITS-1:0] wordT;

    // Bit i enables byte lane i
    typedef logic [BYTE_LANES-1:0] byteEnT;

    typedef enum logic [2:0] {
        IDLE,
        LOOKUP,
        WRITEBACK,
        REFILL_REQ,
        REFILL_WAIT,
        RESPOND
    } ctrlStateT;

endpackage

`default_nettype wire
